/* hdl/hbus_apb_port.sv */
// APB slave without pslverr or strobes; writes are posted, a read stalls its transfer until data returns
module hbus_apb_port import hbus_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       clk,
  input  logic       hbus_rst,
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  hbus_addr_t paddr_i,
  input  hbus_word_t pwdata_i,
  output hbus_word_t prdata_o,
  output logic       pready_o,
  output logic       cmd_valid_o,
  output hbus_cmd_t  cmd_o,
  input  logic       cmd_pop_i,
  input  hbus_word_t rdata_i,
  input  logic       rvalid_i
);

  logic       access;
  logic       fifo_full;
  logic       fifo_empty;
  logic       push;
  logic       wr_push;
  logic       rd_push;
  logic       rd_pending;
  logic       rd_done;
  hbus_cmd_t  new_cmd;

  // Access phase of an APB transfer
  assign access = psel_i && penable_i;

  // A write is posted as soon as there is room
  assign wr_push = access && pwrite_i && !fifo_full;

  // A read is queued once, then waits for its word
  assign rd_push = access && !pwrite_i && !rd_pending && !fifo_full;
  assign rd_done = access && !pwrite_i && rd_pending && rvalid_i;

  assign push = wr_push || rd_push;

  always_comb begin
    if (pwrite_i) begin
      new_cmd = {CMD_WRITE, paddr_i, pwdata_i};
    end else begin
      new_cmd = {CMD_READ, paddr_i, hbus_word_t'('0)};
    end
  end

  hbus_sync_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) cmd_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .push_i   (push),
    .pop_i    (cmd_pop_i),
    .din_i    (new_cmd),
    .dout_o   (cmd_o),
    .full_o   (fifo_full),
    .empty_o  (fifo_empty)
  );

  assign cmd_valid_o = !fifo_empty;

  // Set when the read is queued, cleared when its word comes back
  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      rd_pending <= 1'b0;
    end else if (rd_push) begin
      rd_pending <= 1'b1;
    end else if (rvalid_i) begin
      rd_pending <= 1'b0;
    end
  end

  assign pready_o = wr_push || rd_done;

  // Read word is only sampled by the requester in the pready cycle
  assign prdata_o = rdata_i;

endmodule

/* hdl/hbus_arbiter.sv */
// Round-robin between exactly two ports; grant is held from accept until done, no cross-port ordering
module hbus_arbiter import hbus_pkg::*; (
  input  logic       clk,
  input  logic       hbus_rst,
  input  logic       p0_cmd_valid_i,
  input  logic       p1_cmd_valid_i,
  input  hbus_cmd_t  p0_cmd_i,
  input  hbus_cmd_t  p1_cmd_i,
  output logic       p0_cmd_pop_o,
  output logic       p1_cmd_pop_o,
  output logic       p0_rvalid_o,
  output logic       p1_rvalid_o,
  output hbus_word_t rdata_o,
  output logic       req_valid_o,
  output hbus_cmd_t  req_cmd_o,
  input  logic       req_accept_i,
  input  logic       done_i,
  input  hbus_word_t rdata_i
);

  localparam int DIR_BIT = $bits(hbus_cmd_t) - 1;

  logic busy;
  logic grant;
  logic last_served;
  logic grant_is_read;
  logic pick;

  // When both wait, serve the port that did not go last
  always_comb begin
    if (p0_cmd_valid_i && p1_cmd_valid_i) begin
      pick = ~last_served;
    end else begin
      pick = p1_cmd_valid_i;
    end
  end

  assign req_valid_o = !busy && (p0_cmd_valid_i || p1_cmd_valid_i);
  assign req_cmd_o   = pick ? p1_cmd_i : p0_cmd_i;

  // Accept only happens while idle, so pick is still the chosen port
  assign p0_cmd_pop_o = req_accept_i && !pick;
  assign p1_cmd_pop_o = req_accept_i && pick;

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      busy          <= 1'b0;
      grant         <= 1'b0;
      last_served   <= 1'b1;
      grant_is_read <= 1'b0;
    end else if (req_accept_i) begin
      busy          <= 1'b1;
      grant         <= pick;
      grant_is_read <= (req_cmd_o[DIR_BIT] == CMD_READ);
    end else if (done_i) begin
      busy        <= 1'b0;
      last_served <= grant;
    end
  end

  // Done becomes rvalid for the owner, reads only
  assign p0_rvalid_o = done_i && grant_is_read && !grant;
  assign p1_rvalid_o = done_i && grant_is_read && grant;
  assign rdata_o     = rdata_i;

endmodule

/* hdl/hbus_pkg.sv */
// One clock domain only; command entries carry a full 32-bit word, with no strobes or bursts
package hbus_pkg;

  // Word address, used on APB and on the memory bus
  typedef logic [31:0] hbus_addr_t;

  // User data word and one memory beat
  typedef logic [31:0] hbus_word_t;
  typedef logic [15:0] hbus_beat_t;

  // Queued command entry, laid out as {direction, address, write data}
  typedef logic [64:0] hbus_cmd_t;

  // Direction bit values
  localparam logic CMD_READ  = 1'b1;
  localparam logic CMD_WRITE = 1'b0;

  // Memory beats that make up one word
  localparam int BEATS_PER_WORD = 2;

  typedef enum logic [1:0] {
    SER_IDLE,
    SER_WRITE,
    SER_READ
  } ser_state_t;

endpackage

/* hdl/hbus_serializer.sv */
// Single-word transfers of two 16-bit beats, upper half first; no bursts and no busy handling
module hbus_serializer import hbus_pkg::*; (
  input  logic       clk,
  input  logic       hbus_rst,
  input  logic       req_valid_i,
  input  hbus_cmd_t  req_cmd_i,
  output logic       req_accept_o,
  output logic       done_o,
  output hbus_word_t rdata_o,
  output hbus_addr_t hbus_adr_o,
  output hbus_beat_t hbus_dat_o,
  input  hbus_beat_t hbus_dat_i,
  output logic       hbus_rrq_o,
  output logic       hbus_wrq_o,
  input  logic       hbus_ready_i,
  input  logic       hbus_valid_i
);

  localparam int WORD_W = $bits(hbus_word_t);
  localparam int BEAT_W = $bits(hbus_beat_t);
  localparam int CNT_W  = $clog2(BEATS_PER_WORD);
  localparam logic [CNT_W-1:0] BEAT_LAST = CNT_W'(BEATS_PER_WORD - 1);

  ser_state_t       state;
  logic [CNT_W-1:0] beat_cnt;
  hbus_word_t       tx_shift;
  hbus_word_t       rx_shift;
  logic             req_dir;
  hbus_addr_t       req_addr;
  hbus_word_t       req_data;
  logic             beat_step;
  logic             last_beat;

  assign {req_dir, req_addr, req_data} = req_cmd_i;

  assign req_accept_o = (state == SER_IDLE) && req_valid_i;

  // A beat moves when the memory takes or delivers it
  assign beat_step = ((state == SER_WRITE) && hbus_ready_i) ||
                     ((state == SER_READ) && hbus_valid_i);
  assign last_beat = beat_step && (beat_cnt == BEAT_LAST);

  // Requests follow the state, so they drop right after the final beat
  assign hbus_wrq_o = (state == SER_WRITE);
  assign hbus_rrq_o = (state == SER_READ);

  assign hbus_dat_o = tx_shift[WORD_W-1 -: BEAT_W];
  assign rdata_o    = rx_shift;

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      state    <= SER_IDLE;
      beat_cnt <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        SER_IDLE: begin
          beat_cnt <= '0;
          if (req_accept_o) begin
            state <= (req_dir == CMD_READ) ? SER_READ : SER_WRITE;
          end
        end
        SER_WRITE, SER_READ: begin
          if (last_beat) begin
            // Word is complete, done lands in the next cycle
            state  <= SER_IDLE;
            done_o <= 1'b1;
          end else if (beat_step) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        default: state <= SER_IDLE;
      endcase
    end
  end

  // Address and shift registers carry payload only
  always_ff @(posedge clk) begin
    if (req_accept_o) begin
      hbus_adr_o <= req_addr;
      tx_shift   <= req_data;
    end else if ((state == SER_WRITE) && beat_step) begin
      tx_shift <= tx_shift << BEAT_W;
    end
    if ((state == SER_READ) && beat_step) begin
      rx_shift <= {rx_shift[WORD_W-BEAT_W-1:0], hbus_dat_i};
    end
  end

endmodule

/* hdl/hbus_sync_fifo.sv */
// Single-clock FIFO; push while full and pop while empty are ignored, FIFO_DEPTH must be 2 or more
module hbus_sync_fifo import hbus_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic      clk,
  input  logic      hbus_rst,
  input  logic      push_i,
  input  logic      pop_i,
  input  hbus_cmd_t din_i,
  output hbus_cmd_t dout_o,
  output logic      full_o,
  output logic      empty_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);

  hbus_cmd_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign full_o  = (count == CNT_W'(FIFO_DEPTH));
  assign empty_o = (count == '0);

  // Head entry is always visible
  assign dout_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap by compare so any depth works
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hdl/hbus_top.sv */
// Two APB ports share one memory bus; the memory device itself sits outside this block
module hbus_top import hbus_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       clk,
  input  logic       hbus_rst,
  input  logic       p0_psel_i,
  input  logic       p0_penable_i,
  input  logic       p0_pwrite_i,
  input  hbus_addr_t p0_paddr_i,
  input  hbus_word_t p0_pwdata_i,
  output hbus_word_t p0_prdata_o,
  output logic       p0_pready_o,
  input  logic       p1_psel_i,
  input  logic       p1_penable_i,
  input  logic       p1_pwrite_i,
  input  hbus_addr_t p1_paddr_i,
  input  hbus_word_t p1_pwdata_i,
  output hbus_word_t p1_prdata_o,
  output logic       p1_pready_o,
  output hbus_addr_t hbus_adr_o,
  output hbus_beat_t hbus_dat_o,
  input  hbus_beat_t hbus_dat_i,
  output logic       hbus_rrq_o,
  output logic       hbus_wrq_o,
  input  logic       hbus_ready_i,
  input  logic       hbus_valid_i
);

  logic       p0_cmd_valid;
  logic       p1_cmd_valid;
  hbus_cmd_t  p0_cmd;
  hbus_cmd_t  p1_cmd;
  logic       p0_cmd_pop;
  logic       p1_cmd_pop;
  logic       p0_rvalid;
  logic       p1_rvalid;
  hbus_word_t port_rdata;
  logic       req_valid;
  hbus_cmd_t  req_cmd;
  logic       req_accept;
  logic       ser_done;
  hbus_word_t ser_rdata;

  hbus_apb_port #(.FIFO_DEPTH(FIFO_DEPTH)) port0 (
    .clk (clk), .hbus_rst (hbus_rst),
    .psel_i (p0_psel_i), .penable_i (p0_penable_i), .pwrite_i (p0_pwrite_i),
    .paddr_i (p0_paddr_i), .pwdata_i (p0_pwdata_i),
    .prdata_o (p0_prdata_o), .pready_o (p0_pready_o),
    .cmd_valid_o (p0_cmd_valid), .cmd_o (p0_cmd), .cmd_pop_i (p0_cmd_pop),
    .rdata_i (port_rdata), .rvalid_i (p0_rvalid)
  );

  hbus_apb_port #(.FIFO_DEPTH(FIFO_DEPTH)) port1 (
    .clk (clk), .hbus_rst (hbus_rst),
    .psel_i (p1_psel_i), .penable_i (p1_penable_i), .pwrite_i (p1_pwrite_i),
    .paddr_i (p1_paddr_i), .pwdata_i (p1_pwdata_i),
    .prdata_o (p1_prdata_o), .pready_o (p1_pready_o),
    .cmd_valid_o (p1_cmd_valid), .cmd_o (p1_cmd), .cmd_pop_i (p1_cmd_pop),
    .rdata_i (port_rdata), .rvalid_i (p1_rvalid)
  );

  hbus_arbiter arbiter (
    .clk (clk), .hbus_rst (hbus_rst),
    .p0_cmd_valid_i (p0_cmd_valid), .p1_cmd_valid_i (p1_cmd_valid),
    .p0_cmd_i (p0_cmd), .p1_cmd_i (p1_cmd),
    .p0_cmd_pop_o (p0_cmd_pop), .p1_cmd_pop_o (p1_cmd_pop),
    .p0_rvalid_o (p0_rvalid), .p1_rvalid_o (p1_rvalid), .rdata_o (port_rdata),
    .req_valid_o (req_valid), .req_cmd_o (req_cmd), .req_accept_i (req_accept),
    .done_i (ser_done), .rdata_i (ser_rdata)
  );

  hbus_serializer serializer (
    .clk (clk), .hbus_rst (hbus_rst),
    .req_valid_i (req_valid), .req_cmd_i (req_cmd), .req_accept_o (req_accept),
    .done_o (ser_done), .rdata_o (ser_rdata),
    .hbus_adr_o (hbus_adr_o), .hbus_dat_o (hbus_dat_o), .hbus_dat_i (hbus_dat_i),
    .hbus_rrq_o (hbus_rrq_o), .hbus_wrq_o (hbus_wrq_o),
    .hbus_ready_i (hbus_ready_i), .hbus_valid_i (hbus_valid_i)
  );

endmodule

/* tb.f */
hdl/hbus_pkg.sv
hdl/hbus_sync_fifo.sv
hdl/hbus_apb_port.sv
hdl/hbus_arbiter.sv
hdl/hbus_serializer.sv
hdl/hbus_top.sv
test/hbus_props.sv
test/tb_hbus.sv

/* test/hbus_props.sv */
// Bound into hbus_top; assumes reset is released between clock edges and the APB inputs stay idle in reset
module hbus_props import hbus_pkg::*; (
  input logic       clk,
  input logic       hbus_rst,
  input logic       hbus_rrq_i,
  input logic       hbus_wrq_i,
  input hbus_addr_t hbus_adr_i,
  input logic       p0_pready_i,
  input logic       p1_pready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic mem_req;

  assign mem_req = hbus_rrq_i || hbus_wrq_i;

  // Only one direction on the memory bus at a time
  a_one_direction: assert property (@(posedge clk) disable iff (hbus_rst)
    !(hbus_rrq_i && hbus_wrq_i))
    else $error("Memory read and write requests high together");

  // Address is latched at accept and must hold for the whole word
  a_adr_stable: assert property (@(posedge clk) disable iff (hbus_rst)
    (mem_req && $past(mem_req)) |-> $stable(hbus_adr_i))
    else $error("Memory address changed during a request");

  a_pready_reset: assert property (@(posedge clk)
    $fell(hbus_rst) |-> (!p0_pready_i && !p1_pready_i))
    else $error("pready high in the first cycle after reset");

endmodule

bind hbus_top hbus_props props_i (
  .clk         (clk),
  .hbus_rst    (hbus_rst),
  .hbus_rrq_i  (hbus_rrq_o),
  .hbus_wrq_i  (hbus_wrq_o),
  .hbus_adr_i  (hbus_adr_o),
  .p0_pready_i (p0_pready_o),
  .p1_pready_i (p1_pready_o)
);

/* test/tb_hbus.sv */
// Memory device modeled here as 256 words; port 0 uses addresses 0 to 127, port 1 uses 128 to 255
module tb_hbus import hbus_pkg::*;;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH   = 4;
  localparam int TIMEOUT = 500;

  logic       clk = 1'b0;
  logic       hbus_rst;
  logic       p0_psel, p0_penable, p0_pwrite, p0_pready;
  logic       p1_psel, p1_penable, p1_pwrite, p1_pready;
  hbus_addr_t p0_paddr, p1_paddr, hbus_adr_o;
  hbus_word_t p0_pwdata, p1_pwdata, p0_prdata, p1_prdata;
  hbus_beat_t hbus_dat_o, hbus_dat_i;
  logic       hbus_rrq_o, hbus_wrq_o, hbus_ready_i, hbus_valid_i;

  integer      seed = 32'h0281e74e;
  hbus_word_t  mem [256];
  hbus_word_t  ref_mem [256];
  logic [63:0] exp_wr0 [$];
  logic [63:0] exp_wr1 [$];
  int          rd_beat;
  int          wr_beat;
  hbus_beat_t  wr_beats [2];

  hbus_top #(.FIFO_DEPTH(DEPTH)) hbus_top_i (
    .clk (clk), .hbus_rst (hbus_rst),
    .p0_psel_i (p0_psel), .p0_penable_i (p0_penable), .p0_pwrite_i (p0_pwrite),
    .p0_paddr_i (p0_paddr), .p0_pwdata_i (p0_pwdata),
    .p0_prdata_o (p0_prdata), .p0_pready_o (p0_pready),
    .p1_psel_i (p1_psel), .p1_penable_i (p1_penable), .p1_pwrite_i (p1_pwrite),
    .p1_paddr_i (p1_paddr), .p1_pwdata_i (p1_pwdata),
    .p1_prdata_o (p1_prdata), .p1_pready_o (p1_pready),
    .hbus_adr_o (hbus_adr_o), .hbus_dat_o (hbus_dat_o), .hbus_dat_i (hbus_dat_i),
    .hbus_rrq_o (hbus_rrq_o), .hbus_wrq_o (hbus_wrq_o),
    .hbus_ready_i (hbus_ready_i), .hbus_valid_i (hbus_valid_i)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // Start contents differ for every word address
  function automatic hbus_word_t fill_word(input int idx);
    return {8'(idx), 8'(~idx), 8'(idx * 3), 8'hc3};
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(input hbus_word_t got, input hbus_word_t exp, input string what);
    if (got !== exp)
      stop_run($sformatf("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_beat(input hbus_beat_t got, input hbus_beat_t exp, input string what);
    if (got !== exp)
      stop_run($sformatf("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_addr(input hbus_addr_t got, input hbus_addr_t exp, input string what);
    if (got !== exp)
      stop_run($sformatf("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_run($sformatf("ERROR %0t ns: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic drive_port(input int port, input logic sel, input logic en, input logic wr,
                            input hbus_addr_t addr, input hbus_word_t data);
    if (port == 0) begin
      p0_psel = sel;
      p0_penable = en;
      p0_pwrite = wr;
      p0_paddr = addr;
      p0_pwdata = data;
    end else begin
      p1_psel = sel;
      p1_penable = en;
      p1_pwrite = wr;
      p1_paddr = addr;
      p1_pwdata = data;
    end
  endtask

  // Setup phase, then access phase until pready; returns with the transfer's last cycle open
  task automatic apb_access(input int port, input logic wr, input hbus_addr_t addr,
                            input hbus_word_t wdata, output hbus_word_t rdata,
                            output int waited);
    @(negedge clk);
    drive_port(port, 1'b1, 1'b0, wr, addr, wdata);
    @(negedge clk);
    drive_port(port, 1'b1, 1'b1, wr, addr, wdata);
    #1;
    waited = 0;
    while (((port == 0) ? p0_pready : p1_pready) !== 1'b1) begin
      if (waited >= TIMEOUT)
        stop_run($sformatf("Timeout: APB transfer on port %0d never completed", port));
      else begin
        @(negedge clk);
        #1;
        waited++;
      end
    end
    rdata = (port == 0) ? p0_prdata : p1_prdata;
  endtask

  task automatic apb_write(input int port, input hbus_addr_t addr, input hbus_word_t data,
                           output int waited);
    hbus_word_t unused;
    apb_access(port, 1'b1, addr, data, unused, waited);
    ref_mem[addr[7:0]] = data;
    if (port == 0) exp_wr0.push_back({addr, data});
    else exp_wr1.push_back({addr, data});
  endtask

  task automatic apb_read(input int port, input hbus_addr_t addr);
    hbus_word_t got;
    int         waited;
    apb_access(port, 1'b0, addr, '0, got, waited);
    check_word(got, ref_mem[addr[7:0]], $sformatf("port %0d read of %0d", port, addr));
  endtask

  task automatic end_transfers(input int port);
    @(negedge clk);
    drive_port(port, 1'b0, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic random_traffic(input int port, input int count);
    logic [31:0] rnd;
    hbus_addr_t  base;
    int          waited;
    base = (port == 0) ? 0 : 128;
    for (int i = 0; i < count; i++) begin
      rnd = $random(seed);
      // Narrow range so reads often hit earlier writes
      if (rnd[8]) apb_write(port, base + rnd[4:0], $random(seed), waited);
      else apb_read(port, base + rnd[4:0]);
    end
    end_transfers(port);
  endtask

  // Write beats must match the oldest pending APB write of the same port
  task automatic check_memory_write(input hbus_addr_t addr, input hbus_beat_t hi,
                                    input hbus_beat_t lo);
    logic [63:0] exp;
    if ((addr < 128) ? (exp_wr0.size() == 0) : (exp_wr1.size() == 0))
      stop_run($sformatf("Memory write to %0d with no APB write pending", addr));
    else begin
      exp = (addr < 128) ? exp_wr0.pop_front() : exp_wr1.pop_front();
      check_addr(addr, exp[63:32], "memory write address");
      check_beat(hi, exp[31:16], "upper write beat");
      check_beat(lo, exp[15:0], "lower write beat");
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_wr0.size() != 0 || exp_wr1.size() != 0 || hbus_wrq_o || hbus_rrq_o) begin
      if (waited >= TIMEOUT) stop_run("Timeout: queued writes never reached the memory");
      else begin
        @(negedge clk);
        #1;
        waited++;
      end
    end
  endtask

  task automatic check_reset_outputs();
    check_bit(hbus_rrq_o, 1'b0, "hbus_rrq_o after reset");
    check_bit(hbus_wrq_o, 1'b0, "hbus_wrq_o after reset");
    check_bit(p0_pready, 1'b0, "p0 pready after reset");
    check_bit(p1_pready, 1'b0, "p1 pready after reset");
  endtask

  // Memory device with random stalls; beat events are sampled while the inputs are settled
  always @(negedge clk) begin
    hbus_ready_i = 1'($random(seed));
    hbus_valid_i = 1'($random(seed));
    if (rd_beat == 0) hbus_dat_i = mem[hbus_adr_o[7:0]][31:16];
    else hbus_dat_i = mem[hbus_adr_o[7:0]][15:0];
    #1;
    if (hbus_rrq_o && hbus_wrq_o) stop_run("Memory read and write requests were high together");
    else begin
      if (hbus_rrq_o && hbus_valid_i) rd_beat = (rd_beat == 1) ? 0 : 1;
      if (hbus_wrq_o && hbus_ready_i) begin
        wr_beats[wr_beat] = hbus_dat_o;
        wr_beat++;
        if (wr_beat == 2) begin
          wr_beat = 0;
          mem[hbus_adr_o[7:0]] = {wr_beats[0], wr_beats[1]};
          check_memory_write(hbus_adr_o, wr_beats[0], wr_beats[1]);
        end
      end
    end
  end

  initial begin
    int waited;
    hbus_rst = 1'b1;
    drive_port(0, 1'b0, 1'b0, 1'b0, '0, '0);
    drive_port(1, 1'b0, 1'b0, 1'b0, '0, '0);
    hbus_ready_i = 1'b0;
    hbus_valid_i = 1'b0;
    hbus_dat_i = '0;
    rd_beat = 0;
    wr_beat = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (2) @(negedge clk);
    hbus_rst = 1'b0;
    #1;
    check_reset_outputs();

    // Write then read back on one port
    apb_write(0, 5, $random(seed), waited);
    apb_read(0, 5);
    end_transfers(0);

    // Back-to-back writes fit in the FIFO without waiting
    for (int i = 0; i < DEPTH + 2; i++) begin
      apb_write(1, 128 + i, $random(seed), waited);
      if (i < DEPTH) check_bit(waited == 0, 1'b1, "write accepted without wait");
    end
    for (int i = 0; i < DEPTH + 2; i++) apb_read(1, 128 + i);
    end_transfers(1);

    fork
      random_traffic(0, 60);
      random_traffic(1, 60);
    join
    wait_drained();

    // Memory contents survive a reset of the bridge
    @(negedge clk);
    hbus_rst = 1'b1;
    repeat (2) @(negedge clk);
    hbus_rst = 1'b0;
    #1;
    check_reset_outputs();
    apb_read(0, 5);
    end_transfers(0);

    $display("*** PASSED ***");
    $finish;
  end

endmodule
